// File: src/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// address and data widths
`define LSU_ADDR_W 16
`define LSU_DATA_W 32

// instruction tag and dispatch age
`define LSU_TAG_W 4
`define LSU_AGE_W 4

// queue depths
`define LSU_LDQ_DEPTH 4
`define LSU_STQ_DEPTH 4

// one data word per line
`define L1D_LINES 8

`endif

// File: src/lsu_pkg.sv
`include "lsu_config.svh"

package lsu_pkg;

  // --------------------
  // queue entries
  // --------------------

  // 24 bits
  typedef struct packed {
    logic [`LSU_TAG_W-1:0]  tag;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_AGE_W-1:0]  age;
  } ld_entry_t;

  // 56 bits
  typedef struct packed {
    logic [`LSU_TAG_W-1:0]  tag;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] data;
    logic [`LSU_AGE_W-1:0]  age;
  } st_entry_t;

  // --------------------
  // miss requester
  // --------------------
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    READ      = 2'd1,
    WRITE     = 2'd2,
    WAIT_RESP = 2'd3
  } lrq_state_t;

endpackage

// File: src/lsu_queue.sv
`timescale 1ns/10ps

module lsu_queue #(
  parameter type entry_t = logic [7:0],
  parameter int  DEPTH   = 4
) (
  input  logic   i_clk,
  input  logic   i_reset_n,
  input  logic   i_push,
  input  entry_t i_entry,
  input  logic   i_pop,
  output logic   o_head_valid,
  output entry_t o_head,
  output logic   o_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  entry_t           r_mem [DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [CNT_W-1:0] r_count;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (i_push) begin
        r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
      end
      if (i_pop) begin
        r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
      end
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      r_mem[r_wr_ptr] <= i_entry;
    end
  end

  assign o_head_valid = (r_count != '0);
  assign o_head       = r_mem[r_rd_ptr];
  assign o_full       = (r_count == CNT_W'(DEPTH));

  a_no_push_full : assert property (@(posedge i_clk) disable iff (!i_reset_n) i_push |-> !o_full);
  a_no_pop_empty : assert property (@(posedge i_clk) disable iff (!i_reset_n) i_pop |-> o_head_valid);

endmodule

// File: src/l1d_cache.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module l1d_cache (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_rd_valid,
  input  logic [`LSU_ADDR_W-1:0] i_rd_addr,
  input  logic                   i_wr_valid,
  input  logic [`LSU_ADDR_W-1:0] i_wr_addr,
  input  logic [`LSU_DATA_W-1:0] i_wr_data,
  input  logic                   i_fill_valid,
  input  logic [`LSU_ADDR_W-1:0] i_fill_addr,
  input  logic [`LSU_DATA_W-1:0] i_fill_data,
  output logic                   o_rd_hit,
  output logic [`LSU_DATA_W-1:0] o_rd_data
);

  localparam int OFF_W  = $clog2(`LSU_DATA_W / 8);
  localparam int IDX_W  = $clog2(`L1D_LINES);
  localparam int CTAG_W = `LSU_ADDR_W - OFF_W - IDX_W;

  logic [`L1D_LINES-1:0]  r_valid;
  logic [CTAG_W-1:0]      r_tag  [`L1D_LINES];
  logic [`LSU_DATA_W-1:0] r_data [`L1D_LINES];

  logic [IDX_W-1:0] w_rd_idx;
  logic [IDX_W-1:0] w_wr_idx;
  logic [IDX_W-1:0] w_fill_idx;
  logic             w_rd_match;
  logic             w_wr_match;

  assign w_rd_idx   = i_rd_addr[OFF_W +: IDX_W];
  assign w_wr_idx   = i_wr_addr[OFF_W +: IDX_W];
  assign w_fill_idx = i_fill_addr[OFF_W +: IDX_W];

  assign w_rd_match = r_valid[w_rd_idx] & (r_tag[w_rd_idx] == i_rd_addr[`LSU_ADDR_W-1 -: CTAG_W]);
  assign w_wr_match = r_valid[w_wr_idx] & (r_tag[w_wr_idx] == i_wr_addr[`LSU_ADDR_W-1 -: CTAG_W]);

  // valid bits only ever get set by a refill
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid  <= '0;
      o_rd_hit <= 1'b0;
    end else begin
      if (i_fill_valid) begin
        r_valid[w_fill_idx] <= 1'b1;
      end
      o_rd_hit <= i_rd_valid & w_rd_match;
    end
  end

  // --------------------
  // tag and data arrays
  // --------------------
  always_ff @(posedge i_clk) begin
    if (i_fill_valid) begin
      r_tag[w_fill_idx]  <= i_fill_addr[`LSU_ADDR_W-1 -: CTAG_W];
      r_data[w_fill_idx] <= i_fill_data;
    end else if (i_wr_valid && w_wr_match) begin
      r_data[w_wr_idx] <= i_wr_data;
    end
    if (i_rd_valid) begin
      o_rd_data <= r_data[w_rd_idx];
    end
  end

  a_no_wr_with_fill : assert property (
    @(posedge i_clk) disable iff (!i_reset_n) !(i_wr_valid && i_fill_valid)
  );

endmodule

// File: src/l1d_miss_requester.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module l1d_miss_requester
  import lsu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_req_valid,
  input  logic                   i_req_write,
  input  logic [`LSU_ADDR_W-1:0] i_req_addr,
  input  logic [`LSU_DATA_W-1:0] i_req_data,
  input  logic                   i_ext_req_ready,
  input  logic                   i_ext_resp_valid,
  input  logic [`LSU_DATA_W-1:0] i_ext_resp_data,
  output logic                   o_busy,
  output logic                   o_resolve,
  output logic                   o_fill_valid,
  output logic [`LSU_ADDR_W-1:0] o_fill_addr,
  output logic [`LSU_DATA_W-1:0] o_fill_data,
  output logic                   o_ext_req_valid,
  output logic                   o_ext_req_write,
  output logic [`LSU_ADDR_W-1:0] o_ext_req_addr,
  output logic [`LSU_DATA_W-1:0] o_ext_req_data
);

  lrq_state_t             r_state;
  logic [`LSU_ADDR_W-1:0] r_addr;
  logic [`LSU_DATA_W-1:0] r_data;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IDLE;
    end else begin
      case (r_state)
        IDLE:      if (i_req_valid) r_state <= i_req_write ? WRITE : READ;
        READ:      if (i_ext_req_ready) r_state <= WAIT_RESP;
        WRITE:     if (i_ext_req_ready) r_state <= IDLE;
        WAIT_RESP: if (i_ext_resp_valid) r_state <= IDLE;
        default:   r_state <= IDLE;
      endcase
    end
  end

  // held request
  always_ff @(posedge i_clk) begin
    if ((r_state == IDLE) && i_req_valid) begin
      r_addr <= i_req_addr;
      r_data <= i_req_data;
    end
  end

  assign o_busy          = (r_state != IDLE);
  assign o_ext_req_valid = (r_state == READ) | (r_state == WRITE);
  assign o_ext_req_write = (r_state == WRITE);
  assign o_ext_req_addr  = r_addr;
  assign o_ext_req_data  = r_data;

  // refill goes straight into the cache with the response
  assign o_fill_valid = (r_state == WAIT_RESP) & i_ext_resp_valid;
  assign o_fill_addr  = r_addr;
  assign o_fill_data  = i_ext_resp_data;

  // writes finish on acceptance
  assign o_resolve = o_fill_valid | ((r_state == WRITE) & i_ext_req_ready);

  a_resp_in_wait : assert property (
    @(posedge i_clk) disable iff (!i_reset_n) i_ext_resp_valid |-> (r_state == WAIT_RESP)
  );

endmodule

// File: src/lsu_pipe.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_pipe
  import lsu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  // queue side
  input  logic                   i_ld_head_valid,
  input  ld_entry_t              i_ld_head,
  input  logic                   i_st_head_valid,
  input  st_entry_t              i_st_head,
  output logic                   o_ld_pop,
  output logic                   o_st_pop,
  // cache side
  output logic                   o_rd_valid,
  output logic [`LSU_ADDR_W-1:0] o_rd_addr,
  output logic                   o_wr_valid,
  output logic [`LSU_ADDR_W-1:0] o_wr_addr,
  output logic [`LSU_DATA_W-1:0] o_wr_data,
  input  logic                   i_rd_hit,
  input  logic [`LSU_DATA_W-1:0] i_rd_data,
  // requester side
  output logic                   o_lrq_valid,
  output logic                   o_lrq_write,
  output logic [`LSU_ADDR_W-1:0] o_lrq_addr,
  output logic [`LSU_DATA_W-1:0] o_lrq_data,
  input  logic                   i_lrq_busy,
  input  logic                   i_resolve,
  // done report
  output logic                   o_done_valid,
  output logic [`LSU_TAG_W-1:0]  o_done_tag,
  output logic [`LSU_DATA_W-1:0] o_done_data
);

  // replay waits a cycle so the refilled line is readable
  typedef enum logic [2:0] {
    P_IDLE, P_EX1, P_EX2, P_WAIT, P_REPLAY
  } pipe_state_t;

  pipe_state_t            r_state;
  logic                   r_op_is_store;
  logic [`LSU_TAG_W-1:0]  r_op_tag;
  logic [`LSU_ADDR_W-1:0] r_op_addr;
  logic [`LSU_DATA_W-1:0] r_op_data;
  logic                   r_hit;
  logic [`LSU_DATA_W-1:0] r_data;

  logic [`LSU_AGE_W-1:0] w_age_diff;
  logic                  w_ld_older;
  logic                  w_issue_ld;
  logic                  w_issue_st;
  logic                  w_lrq_send;
  logic                  w_done_ld;
  logic                  w_done_st;

  // --------------------
  // issue by age
  // --------------------
  // negative difference means the load was dispatched first
  assign w_age_diff = i_ld_head.age - i_st_head.age;
  assign w_ld_older = i_ld_head_valid & (!i_st_head_valid | w_age_diff[`LSU_AGE_W-1]);
  assign w_issue_ld = (r_state == P_IDLE) & w_ld_older;
  assign w_issue_st = (r_state == P_IDLE) & i_st_head_valid & !w_ld_older;

  assign o_rd_valid = w_issue_ld | w_issue_st | (r_state == P_REPLAY);
  assign o_rd_addr  = (r_state == P_REPLAY) ? r_op_addr :
                      w_issue_ld            ? i_ld_head.addr : i_st_head.addr;

  // --------------------
  // EX2 decide
  // --------------------
  assign w_lrq_send = (r_state == P_EX2) & (r_op_is_store | !r_hit) & !i_lrq_busy;
  assign w_done_ld  = (r_state == P_EX2) & !r_op_is_store & r_hit;
  assign w_done_st  = (r_state == P_WAIT) & r_op_is_store & i_resolve;

  // store hit updates the line alongside the write-through
  assign o_wr_valid = w_lrq_send & r_op_is_store & r_hit;
  assign o_wr_addr  = r_op_addr;
  assign o_wr_data  = r_op_data;

  assign o_lrq_valid = w_lrq_send;
  assign o_lrq_write = r_op_is_store;
  assign o_lrq_addr  = r_op_addr;
  assign o_lrq_data  = r_op_data;

  assign o_done_valid = w_done_ld | w_done_st;
  assign o_done_tag   = r_op_tag;
  assign o_done_data  = r_op_is_store ? r_op_data : r_data;
  assign o_ld_pop     = w_done_ld;
  assign o_st_pop     = w_done_st;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= P_IDLE;
    end else begin
      case (r_state)
        P_IDLE:   if (w_issue_ld || w_issue_st) r_state <= P_EX1;
        P_EX1:    r_state <= P_EX2;
        P_EX2: begin
          if (w_done_ld) begin
            r_state <= P_IDLE;
          end else if (w_lrq_send) begin
            r_state <= P_WAIT;
          end
        end
        P_WAIT: begin
          if (i_resolve) begin
            r_state <= r_op_is_store ? P_IDLE : P_REPLAY;
          end
        end
        P_REPLAY: r_state <= P_EX1;
        default:  r_state <= P_IDLE;
      endcase
    end
  end

  // operation in flight and its lookup result
  always_ff @(posedge i_clk) begin
    if (w_issue_ld || w_issue_st) begin
      r_op_is_store <= w_issue_st;
      r_op_tag      <= w_issue_st ? i_st_head.tag : i_ld_head.tag;
      r_op_addr     <= w_issue_st ? i_st_head.addr : i_ld_head.addr;
      r_op_data     <= i_st_head.data;
    end
    if (r_state == P_EX1) begin
      r_hit  <= i_rd_hit;
      r_data <= i_rd_data;
    end
  end

  // the head popped with a report is the operation that was issued
  a_pop_is_issued_op : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    o_done_valid |-> ((o_ld_pop ? i_ld_head.tag : i_st_head.tag) == o_done_tag)
  );

endmodule

// File: src/lsu_top.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  // dispatch
  input  logic                   i_disp_valid,
  input  logic                   i_disp_is_store,
  input  logic [`LSU_TAG_W-1:0]  i_disp_tag,
  input  logic [`LSU_ADDR_W-1:0] i_disp_addr,
  input  logic [`LSU_DATA_W-1:0] i_disp_data,
  output logic                   o_disp_ld_ready,
  output logic                   o_disp_st_ready,
  // done report
  output logic                   o_done_valid,
  output logic [`LSU_TAG_W-1:0]  o_done_tag,
  output logic [`LSU_DATA_W-1:0] o_done_data,
  // external memory
  input  logic                   i_ext_req_ready,
  input  logic                   i_ext_resp_valid,
  input  logic [`LSU_DATA_W-1:0] i_ext_resp_data,
  output logic                   o_ext_req_valid,
  output logic                   o_ext_req_write,
  output logic [`LSU_ADDR_W-1:0] o_ext_req_addr,
  output logic [`LSU_DATA_W-1:0] o_ext_req_data
);

  logic [`LSU_AGE_W-1:0] r_age;
  logic                  w_ld_push, w_st_push;
  ld_entry_t             w_ld_entry, w_ld_head;
  st_entry_t             w_st_entry, w_st_head;
  logic                  w_ld_head_valid, w_ld_full, w_ld_pop;
  logic                  w_st_head_valid, w_st_full, w_st_pop;

  logic                   w_rd_valid, w_rd_hit, w_wr_valid;
  logic [`LSU_ADDR_W-1:0] w_rd_addr, w_wr_addr;
  logic [`LSU_DATA_W-1:0] w_rd_data, w_wr_data;

  logic                   w_lrq_valid, w_lrq_write, w_lrq_busy, w_resolve;
  logic [`LSU_ADDR_W-1:0] w_lrq_addr, w_fill_addr;
  logic [`LSU_DATA_W-1:0] w_lrq_data, w_fill_data;
  logic                   w_fill_valid;

  // --------------------
  // dispatch split
  // --------------------
  assign o_disp_ld_ready = !w_ld_full;
  assign o_disp_st_ready = !w_st_full;
  assign w_ld_push = i_disp_valid & !i_disp_is_store & o_disp_ld_ready;
  assign w_st_push = i_disp_valid & i_disp_is_store & o_disp_st_ready;

  assign w_ld_entry = '{tag: i_disp_tag, addr: i_disp_addr, age: r_age};
  assign w_st_entry = '{tag: i_disp_tag, addr: i_disp_addr, data: i_disp_data, age: r_age};

  // one age per accepted operation, shared by both queues
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_age <= '0;
    end else if (w_ld_push || w_st_push) begin
      r_age <= r_age + 1'b1;
    end
  end

  lsu_queue #(.entry_t(ld_entry_t), .DEPTH(`LSU_LDQ_DEPTH)) u_ldq (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_push(w_ld_push), .i_entry(w_ld_entry), .i_pop(w_ld_pop),
    .o_head_valid(w_ld_head_valid), .o_head(w_ld_head), .o_full(w_ld_full)
  );

  lsu_queue #(.entry_t(st_entry_t), .DEPTH(`LSU_STQ_DEPTH)) u_stq (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_push(w_st_push), .i_entry(w_st_entry), .i_pop(w_st_pop),
    .o_head_valid(w_st_head_valid), .o_head(w_st_head), .o_full(w_st_full)
  );

  // --------------------
  // pipe, cache, requester
  // --------------------
  lsu_pipe u_lsu_pipe (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_ld_head_valid(w_ld_head_valid), .i_ld_head(w_ld_head),
    .i_st_head_valid(w_st_head_valid), .i_st_head(w_st_head),
    .o_ld_pop(w_ld_pop), .o_st_pop(w_st_pop),
    .o_rd_valid(w_rd_valid), .o_rd_addr(w_rd_addr),
    .o_wr_valid(w_wr_valid), .o_wr_addr(w_wr_addr), .o_wr_data(w_wr_data),
    .i_rd_hit(w_rd_hit), .i_rd_data(w_rd_data),
    .o_lrq_valid(w_lrq_valid), .o_lrq_write(w_lrq_write),
    .o_lrq_addr(w_lrq_addr), .o_lrq_data(w_lrq_data),
    .i_lrq_busy(w_lrq_busy), .i_resolve(w_resolve),
    .o_done_valid(o_done_valid), .o_done_tag(o_done_tag), .o_done_data(o_done_data)
  );

  l1d_cache u_l1d_cache (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_rd_valid(w_rd_valid), .i_rd_addr(w_rd_addr),
    .i_wr_valid(w_wr_valid), .i_wr_addr(w_wr_addr), .i_wr_data(w_wr_data),
    .i_fill_valid(w_fill_valid), .i_fill_addr(w_fill_addr), .i_fill_data(w_fill_data),
    .o_rd_hit(w_rd_hit), .o_rd_data(w_rd_data)
  );

  l1d_miss_requester u_l1d_miss_requester (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_req_valid(w_lrq_valid), .i_req_write(w_lrq_write),
    .i_req_addr(w_lrq_addr), .i_req_data(w_lrq_data),
    .i_ext_req_ready(i_ext_req_ready),
    .i_ext_resp_valid(i_ext_resp_valid), .i_ext_resp_data(i_ext_resp_data),
    .o_busy(w_lrq_busy), .o_resolve(w_resolve),
    .o_fill_valid(w_fill_valid), .o_fill_addr(w_fill_addr), .o_fill_data(w_fill_data),
    .o_ext_req_valid(o_ext_req_valid), .o_ext_req_write(o_ext_req_write),
    .o_ext_req_addr(o_ext_req_addr), .o_ext_req_data(o_ext_req_data)
  );

endmodule

// File: tests/tb_lsu_top.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module tb_lsu_top;

  localparam int CLK_PERIOD = 100;
  localparam int MAX_OPS    = 64;
  localparam int MEM_WORDS  = 1 << (`LSU_ADDR_W - 2);

  logic                   i_clk;
  logic                   i_reset_n;
  logic                   i_disp_valid;
  logic                   i_disp_is_store;
  logic [`LSU_TAG_W-1:0]  i_disp_tag;
  logic [`LSU_ADDR_W-1:0] i_disp_addr;
  logic [`LSU_DATA_W-1:0] i_disp_data;
  logic                   i_ext_req_ready;
  logic                   i_ext_resp_valid;
  logic [`LSU_DATA_W-1:0] i_ext_resp_data;
  logic                   o_disp_ld_ready;
  logic                   o_disp_st_ready;
  logic                   o_done_valid;
  logic [`LSU_TAG_W-1:0]  o_done_tag;
  logic [`LSU_DATA_W-1:0] o_done_data;
  logic                   o_ext_req_valid;
  logic                   o_ext_req_write;
  logic [`LSU_ADDR_W-1:0] o_ext_req_addr;
  logic [`LSU_DATA_W-1:0] o_ext_req_data;

  // operation list from the data file
  byte                    op_kind [MAX_OPS];
  logic [`LSU_TAG_W-1:0]  op_tag  [MAX_OPS];
  logic [`LSU_ADDR_W-1:0] op_addr [MAX_OPS];
  logic [`LSU_DATA_W-1:0] op_data [MAX_OPS];
  int                     n_items;
  int                     n_ops;
  int                     hold_total;
  bit                     file_loaded;

  logic [`LSU_DATA_W-1:0] mem [MEM_WORDS];
  int                     exp_q [$];
  int                     reports_seen;
  int                     hold_cycles;
  bit                     hold_started;
  bit                     ready_dropped;

  lsu_top u_lsu_top (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // --------------------
  // checks
  // --------------------
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_tag(input string name, input logic [`LSU_TAG_W-1:0] exp_tag,
                           input logic [`LSU_TAG_W-1:0] act_tag);
    if (act_tag !== exp_tag) begin
      stop_with_failure($sformatf("error %s: tag expected %h, actual %h", name, exp_tag, act_tag));
    end
  endtask

  task automatic check_data(input string name, input logic [`LSU_DATA_W-1:0] exp_data,
                            input logic [`LSU_DATA_W-1:0] act_data);
    if (act_data !== exp_data) begin
      stop_with_failure($sformatf("error %s: data expected %h, actual %h", name, exp_data,
                                  act_data));
    end
  endtask

  function automatic string op_name(input int idx);
    return $sformatf("op %0d %s tag %h addr %h", idx, (op_kind[idx] == "S") ? "store" : "load",
                     op_tag[idx], op_addr[idx]);
  endfunction

  // byte address and its inverse
  function automatic logic [`LSU_DATA_W-1:0] fill_word(input int word_idx);
    logic [15:0] byte_addr;
    byte_addr = 16'(word_idx * 4);
    return {~byte_addr, byte_addr};
  endfunction

  // --------------------
  // stimulus
  // --------------------
  task automatic load_testdata();
    int          fd;
    int          n;
    string       line;
    byte         kind;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    fd = $fopen("tests/lsu_testdata.txt", "r");
    if (fd == 0) begin
      stop_with_failure("cannot open tests/lsu_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin
          n = $sscanf(line, "%c %h %h %h", kind, f1, f2, f3);
          if (kind == "M") begin
            mem[f1[`LSU_ADDR_W-1:2]] = f2;
          end else if (kind == "L" || kind == "S" || kind == "H") begin
            op_kind[n_items] = kind;
            op_tag[n_items]  = f1[`LSU_TAG_W-1:0];
            op_addr[n_items] = f2[`LSU_ADDR_W-1:0];
            op_data[n_items] = (kind == "H") ? f1 : f3;
            if (kind == "H") hold_total += f1;
            else n_ops++;
            n_items++;
          end else begin
            stop_with_failure($sformatf("unknown line in data file: %s", line));
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // called on a falling edge, returns on a falling edge with valid low
  task automatic dispatch_op(input int idx);
    i_disp_valid    = 1'b1;
    i_disp_is_store = (op_kind[idx] == "S");
    i_disp_tag      = op_tag[idx];
    i_disp_addr     = op_addr[idx];
    i_disp_data     = op_data[idx];
    while (!(i_disp_is_store ? o_disp_st_ready : o_disp_ld_ready)) begin
      if (hold_started) ready_dropped = 1'b1;
      @(negedge i_clk);
    end
    exp_q.push_back(idx);
    @(negedge i_clk);
    i_disp_valid = 1'b0;
  endtask

  initial begin : main
    void'($urandom(32'h6563_3e41));
    i_reset_n        = 1'b0;
    i_disp_valid     = 1'b0;
    i_disp_is_store  = 1'b0;
    i_disp_tag       = '0;
    i_disp_addr      = '0;
    i_disp_data      = '0;
    i_ext_req_ready  = 1'b0;
    i_ext_resp_valid = 1'b0;
    i_ext_resp_data  = '0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_word(i);
    load_testdata();
    file_loaded = 1'b1;

    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    if (!o_disp_ld_ready || !o_disp_st_ready || o_done_valid || o_ext_req_valid) begin
      stop_with_failure("DUT outputs were not idle during reset");
    end
    i_reset_n = 1'b1;

    for (int i = 0; i < n_items; i++) begin
      if (op_kind[i] == "H") begin
        @(posedge i_clk);
        hold_cycles  = op_data[i];
        hold_started = 1'b1;
        @(negedge i_clk);
      end else begin
        dispatch_op(i);
      end
    end

    wait (reports_seen == n_ops);
    repeat (10) @(posedge i_clk);
    if (hold_started && !ready_dropped) begin
      stop_with_failure("dispatch ready never dropped while the memory held ready low");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

  // --------------------
  // external memory model
  // --------------------
  initial begin : memory_model
    bit               pend;
    int               delay;
    logic [13:0]      raddr;
    pend = 1'b0;
    @(posedge i_reset_n);
    forever begin
      @(posedge i_clk);
      if (i_ext_resp_valid) pend = 1'b0;
      if (o_ext_req_valid && i_ext_req_ready) begin
        if (o_ext_req_write) begin
          mem[o_ext_req_addr[`LSU_ADDR_W-1:2]] = o_ext_req_data;
        end else begin
          pend  = 1'b1;
          delay = $urandom % 6;
          raddr = o_ext_req_addr[`LSU_ADDR_W-1:2];
        end
      end
      @(negedge i_clk);
      i_ext_resp_valid = 1'b0;
      if (pend && delay == 0) begin
        i_ext_resp_valid = 1'b1;
        i_ext_resp_data  = mem[raddr];
      end else if (pend) begin
        delay--;
      end
      if (hold_cycles > 0) begin
        i_ext_req_ready = 1'b0;
        hold_cycles--;
      end else begin
        i_ext_req_ready = ($urandom % 4) != 0;
      end
    end
  end

  // done reports against the oldest dispatched operation
  initial begin : done_monitor
    int idx;
    @(posedge i_reset_n);
    forever begin
      @(posedge i_clk);
      if (o_done_valid && exp_q.size() == 0) begin
        stop_with_failure("done report arrived with no operation outstanding");
      end else if (o_done_valid) begin
        idx = exp_q.pop_front();
        check_tag(op_name(idx), op_tag[idx], o_done_tag);
        check_data(op_name(idx), op_data[idx], o_done_data);
        reports_seen++;
      end
    end
  end

  initial begin : watchdog
    wait (file_loaded);
    #((200 * n_ops + hold_total + 100) * CLK_PERIOD);
    stop_with_failure($sformatf("timeout with %0d of %0d done reports seen", reports_seen, n_ops));
  end

endmodule

// File: lsu_top.f
+incdir+src
src/lsu_pkg.sv
src/lsu_queue.sv
src/l1d_cache.sv
src/l1d_miss_requester.sv
src/lsu_pipe.sv
src/lsu_top.sv
tests/tb_lsu_top.sv

// File: Bender.yml
package:
  name: lsu_top

sources:
  - include_dirs:
      - src
    files:
      - src/lsu_pkg.sv
      - src/lsu_queue.sv
      - src/l1d_cache.sv
      - src/l1d_miss_requester.sv
      - src/lsu_pipe.sv
      - src/lsu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/tb_lsu_top.sv

// File: tests/lsu_testdata.txt
# M addr data | L tag addr expected_data | S tag addr data | H cycles
# all fields hex, H holds the external ready low for the given cycles
M 0040 11112222
M 0060 33334444
M 0080 55556666
M 0100 77778888
M 0200 0badf00d
# first load misses, second one hits
L 0 0040 11112222
L 1 0040 11112222
# store then load, on a hit and on a miss
S 2 0040 aaaa0001
L 3 0040 aaaa0001
S 4 0300 bbbb0002
L 5 0300 bbbb0002
# interleaved stores and loads
S 6 0080 cccc0003
L 7 0200 0badf00d
S 8 0204 dddd0004
L 9 0080 cccc0003
L a 0204 dddd0004
L b 0400 fbff0400
# 0040, 0060 and 0100 share line 0
L c 0060 33334444
L d 0040 aaaa0001
L e 0100 77778888
S f 0100 eeee0005
L 0 0060 33334444
L 1 0100 eeee0005
# back-pressure, store queue fills while ready is held low
H 60
S 2 0010 10101010
S 3 0014 20202020
S 4 0018 30303030
S 5 001c 40404040
S 6 0020 50505050
S 7 0024 60606060
L 8 0010 10101010
L 9 0024 60606060
L a 0300 bbbb0002
